//--- hw/dsp_macros.svh
`ifndef DSP_MACROS_SVH
`define DSP_MACROS_SVH

// codes carried in one frame.
`define CHANNEL_WIDTH 4

// signed adc code width.
`define CODE_BITS 8

// ffe weights and channel estimate taps share this width.
`define WEIGHT_BITS 8

// equalizer output after shift and saturation.
`define EST_BITS 10

// right shift amount applied to the ffe sum.
`define SHIFT_BITS 3

// taps of the feed-forward equalizer.
`define FFE_TAPS 3

`endif

//--- hw/dsp_pkg.sv
`include "dsp_macros.svh"

package dsp_pkg;

	// one signed adc sample.
	typedef logic signed [`CODE_BITS-1:0] code_t;

	// ffe weight or channel estimate tap.
	typedef logic signed [`WEIGHT_BITS-1:0] weight_t;

	// saturated equalizer output, also the slicer threshold.
	typedef logic signed [`EST_BITS-1:0] est_t;

	// fill state of the decision history.
	typedef enum logic {
		HIST_EMPTY,
		HIST_PRIMED
	} hist_state_t;

endpackage : dsp_pkg

//--- hw/ffe_slicer.sv
`timescale 1ns/1ps
`include "dsp_macros.svh"

module ffe_slicer (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  valid_i,
	input  dsp_pkg::code_t        codes_i [`CHANNEL_WIDTH-1:0],
	input  dsp_pkg::weight_t      weights_i [`FFE_TAPS-1:0],
	input  logic [`SHIFT_BITS-1:0] ffe_shift_i,
	input  dsp_pkg::est_t         thresh_i,
	output logic                  valid_o,
	output dsp_pkg::est_t         est_o [`CHANNEL_WIDTH-1:0],
	output logic [`CHANNEL_WIDTH-1:0] bits_o,
	output dsp_pkg::code_t        codes_o [`CHANNEL_WIDTH-1:0]
);

	localparam int PROD_BITS = `CODE_BITS + `WEIGHT_BITS;
	localparam int SUM_BITS  = PROD_BITS + 2;
	localparam int TAIL      = `FFE_TAPS - 1;
	localparam int WIN       = `CHANNEL_WIDTH + TAIL;
	localparam int EST_MAX   = 2**(`EST_BITS-1) - 1;
	localparam int EST_MIN   = -(2**(`EST_BITS-1));

	// oldest code of the previous frame sits at index 0.
	dsp_pkg::code_t tail_q [TAIL-1:0];

	dsp_pkg::code_t window [WIN-1:0];
	logic signed [SUM_BITS-1:0] sum_c [`CHANNEL_WIDTH-1:0];
	logic signed [SUM_BITS-1:0] shifted [`CHANNEL_WIDTH-1:0];
	dsp_pkg::est_t est_next [`CHANNEL_WIDTH-1:0];
	logic [`CHANNEL_WIDTH-1:0] bits_next;

	// serial view of the codes, reaching back into the previous frame.
	always_comb begin
		for (int k = 0; k < TAIL; k++) begin
			window[k] = tail_q[k];
		end
		for (int k = 0; k < `CHANNEL_WIDTH; k++) begin
			window[k+TAIL] = codes_i[k];
		end
	end

	// tap j of channel c multiplies code n-j.
	always_comb begin
		logic signed [SUM_BITS-1:0] prod;
		prod = '0;
		for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
			sum_c[c] = '0;
			for (int j = 0; j < `FFE_TAPS; j++) begin
				prod = weights_i[j] * window[c+TAIL-j];
				sum_c[c] = sum_c[c] + prod;
			end
		end
	end

	// shift, clip to the estimate range and slice.
	always_comb begin
		for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
			shifted[c] = sum_c[c] >>> ffe_shift_i;
			if (shifted[c] > EST_MAX) begin
				est_next[c] = dsp_pkg::est_t'(EST_MAX);
			end else if (shifted[c] < EST_MIN) begin
				est_next[c] = dsp_pkg::est_t'(EST_MIN);
			end else begin
				est_next[c] = dsp_pkg::est_t'(shifted[c]);
			end
			bits_next[c] = (est_next[c] >= thresh_i);
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o <= 1'b0;
			bits_o  <= '0;
			for (int k = 0; k < TAIL; k++) begin
				tail_q[k] <= '0;
			end
			for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
				est_o[c]   <= '0;
				codes_o[c] <= '0;
			end
		end else begin
			valid_o <= valid_i;
			if (valid_i) begin
				bits_o <= bits_next;
				for (int k = 0; k < TAIL; k++) begin
					tail_q[k] <= codes_i[`CHANNEL_WIDTH-TAIL+k];
				end
				for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
					est_o[c]   <= est_next[c];
					codes_o[c] <= codes_i[c];
				end
			end
		end
	end

endmodule : ffe_slicer

//--- hw/decision_history.sv
`timescale 1ns/1ps
`include "dsp_macros.svh"

module decision_history (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      valid_i,
	input  dsp_pkg::code_t            codes_i [`CHANNEL_WIDTH-1:0],
	input  logic [`CHANNEL_WIDTH-1:0] bits_i,
	output logic                      valid_o,
	output dsp_pkg::code_t            codes_o [`CHANNEL_WIDTH-1:0],
	output logic [`CHANNEL_WIDTH-1:0] bits_o,
	output logic                      prev_bit_o,
	output logic                      next_bit_o
);

	dsp_pkg::hist_state_t state_q;

	// one frame delay, advancing only when a frame arrives.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= dsp_pkg::HIST_EMPTY;
			bits_o     <= '0;
			prev_bit_o <= 1'b0;
			for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
				codes_o[c] <= '0;
			end
		end else if (valid_i) begin
			state_q <= dsp_pkg::HIST_PRIMED;
			bits_o  <= bits_i;
			// newest bit of the stored frame becomes the left neighbour.
			prev_bit_o <= bits_o[`CHANNEL_WIDTH-1];
			for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
				codes_o[c] <= codes_i[c];
			end
		end
	end

	// the stored frame is checked once its right neighbour shows up.
	assign valid_o = valid_i && (state_q == dsp_pkg::HIST_PRIMED);

	assign next_bit_o = bits_i[0];

endmodule : decision_history

//--- hw/mlsd_checker.sv
`timescale 1ns/1ps
`include "dsp_macros.svh"

module mlsd_checker (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      valid_i,
	input  dsp_pkg::code_t            codes_i [`CHANNEL_WIDTH-1:0],
	input  logic [`CHANNEL_WIDTH-1:0] bits_i,
	input  logic                      prev_bit_i,
	input  logic                      next_bit_i,
	input  dsp_pkg::weight_t          est_pre_i,
	input  dsp_pkg::weight_t          est_main_i,
	input  dsp_pkg::weight_t          est_post_i,
	output logic                      valid_o,
	output logic [`CHANNEL_WIDTH-1:0] checked_bits_o
);

	// three taps of +/- weight need two extra bits.
	localparam int EXP_BITS = `WEIGHT_BITS + 2;
	localparam int ERR_BITS = EXP_BITS + 1;

	logic [`CHANNEL_WIDTH-1:0] left_bit;
	logic [`CHANNEL_WIDTH-1:0] right_bit;
	logic signed [EXP_BITS-1:0] exp0 [`CHANNEL_WIDTH-1:0];
	logic signed [EXP_BITS-1:0] exp1 [`CHANNEL_WIDTH-1:0];
	logic [ERR_BITS-1:0] err0 [`CHANNEL_WIDTH-1:0];
	logic [ERR_BITS-1:0] err1 [`CHANNEL_WIDTH-1:0];
	logic [`CHANNEL_WIDTH-1:0] decision;

	// tap weight times the +1/-1 symbol of a bit.
	function automatic logic signed [EXP_BITS-1:0] apply_sym(
		input dsp_pkg::weight_t w,
		input logic b
	);
		logic signed [EXP_BITS-1:0] w_ext;
		w_ext = w;
		return b ? w_ext : -w_ext;
	endfunction

	function automatic logic [ERR_BITS-1:0] abs_err(
		input dsp_pkg::code_t code,
		input logic signed [EXP_BITS-1:0] expected
	);
		logic signed [ERR_BITS-1:0] diff;
		diff = code - expected;
		return (diff < 0) ? ERR_BITS'(-diff) : ERR_BITS'(diff);
	endfunction

	// neighbours come from the frame itself or from its edges.
	always_comb begin
		for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
			left_bit[c]  = (c == 0) ? prev_bit_i : bits_i[(c+`CHANNEL_WIDTH-1)%`CHANNEL_WIDTH];
			right_bit[c] = (c == `CHANNEL_WIDTH-1) ? next_bit_i : bits_i[(c+1)%`CHANNEL_WIDTH];
		end
	end

	always_comb begin
		for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
			exp0[c] = apply_sym(est_pre_i, right_bit[c]) + apply_sym(est_main_i, 1'b0)
				+ apply_sym(est_post_i, left_bit[c]);
			exp1[c] = apply_sym(est_pre_i, right_bit[c]) + apply_sym(est_main_i, 1'b1)
				+ apply_sym(est_post_i, left_bit[c]);
			err0[c] = abs_err(codes_i[c], exp0[c]);
			err1[c] = abs_err(codes_i[c], exp1[c]);
			// a tie leaves the slicer decision alone.
			if (err1[c] < err0[c]) begin
				decision[c] = 1'b1;
			end else if (err0[c] < err1[c]) begin
				decision[c] = 1'b0;
			end else begin
				decision[c] = bits_i[c];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o        <= 1'b0;
			checked_bits_o <= '0;
		end else begin
			valid_o <= valid_i;
			if (valid_i) begin
				checked_bits_o <= decision;
			end
		end
	end

endmodule : mlsd_checker

//--- hw/dsp_backend.sv
`timescale 1ns/1ps
`include "dsp_macros.svh"

module dsp_backend (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      valid_i,
	input  dsp_pkg::code_t            codes_i [`CHANNEL_WIDTH-1:0],
	input  dsp_pkg::weight_t          weights_i [`FFE_TAPS-1:0],
	input  logic [`SHIFT_BITS-1:0]    ffe_shift_i,
	input  dsp_pkg::est_t             thresh_i,
	input  dsp_pkg::weight_t          est_pre_i,
	input  dsp_pkg::weight_t          est_main_i,
	input  dsp_pkg::weight_t          est_post_i,
	output logic                      est_valid_o,
	output dsp_pkg::est_t             estimated_o [`CHANNEL_WIDTH-1:0],
	output logic                      checked_valid_o,
	output logic [`CHANNEL_WIDTH-1:0] checked_bits_o
);

	logic                      ffe_valid;
	dsp_pkg::est_t             ffe_est [`CHANNEL_WIDTH-1:0];
	logic [`CHANNEL_WIDTH-1:0] ffe_bits;
	dsp_pkg::code_t            ffe_codes [`CHANNEL_WIDTH-1:0];

	logic                      hist_valid;
	dsp_pkg::code_t            hist_codes [`CHANNEL_WIDTH-1:0];
	logic [`CHANNEL_WIDTH-1:0] hist_bits;
	logic                      prev_bit;
	logic                      next_bit;

	ffe_slicer ffe_slicer_i (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.valid_i    (valid_i),
		.codes_i    (codes_i),
		.weights_i  (weights_i),
		.ffe_shift_i(ffe_shift_i),
		.thresh_i   (thresh_i),
		.valid_o    (ffe_valid),
		.est_o      (ffe_est),
		.bits_o     (ffe_bits),
		.codes_o    (ffe_codes)
	);

	decision_history decision_history_i (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.valid_i   (ffe_valid),
		.codes_i   (ffe_codes),
		.bits_i    (ffe_bits),
		.valid_o   (hist_valid),
		.codes_o   (hist_codes),
		.bits_o    (hist_bits),
		.prev_bit_o(prev_bit),
		.next_bit_o(next_bit)
	);

	mlsd_checker mlsd_checker_i (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.valid_i       (hist_valid),
		.codes_i       (hist_codes),
		.bits_i        (hist_bits),
		.prev_bit_i    (prev_bit),
		.next_bit_i    (next_bit),
		.est_pre_i     (est_pre_i),
		.est_main_i    (est_main_i),
		.est_post_i    (est_post_i),
		.valid_o       (checked_valid_o),
		.checked_bits_o(checked_bits_o)
	);

	// equalizer estimates leave one cycle after the input frame.
	assign est_valid_o = ffe_valid;
	assign estimated_o = ffe_est;

endmodule : dsp_backend

//--- sim/tb_dsp_backend.sv
`timescale 1ns/1ps
`include "dsp_macros.svh"

module tb_dsp_backend;

	localparam int MAX_CODES = 600 * `CHANNEL_WIDTH;
	// about 510 frames, gaps of up to 3 idle cycles, plus margin.
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int EST_HI = 2**(`EST_BITS-1) - 1;
	localparam int EST_LO = -(2**(`EST_BITS-1));

	logic clk = 1'b0;
	logic arst_n_i;
	logic valid_i;
	dsp_pkg::code_t codes_i [`CHANNEL_WIDTH-1:0];
	dsp_pkg::weight_t weights_i [`FFE_TAPS-1:0];
	logic [`SHIFT_BITS-1:0] ffe_shift_i;
	dsp_pkg::est_t thresh_i;
	dsp_pkg::weight_t est_pre_i;
	dsp_pkg::weight_t est_main_i;
	dsp_pkg::weight_t est_post_i;
	logic est_valid_o;
	dsp_pkg::est_t estimated_o [`CHANNEL_WIDTH-1:0];
	logic checked_valid_o;
	logic [`CHANNEL_WIDTH-1:0] checked_bits_o;

	int seed = 32'hab02;
	int w_val [`FFE_TAPS];
	int shift_val;
	int thresh_val;
	int pre_val;
	int main_val;
	int post_val;
	int frame_codes [`CHANNEL_WIDTH];
	// serial history, index n = frame * CHANNEL_WIDTH + channel.
	int code_hist [MAX_CODES];
	logic bit_hist [MAX_CODES];
	int frame_count = 0;
	int est_exp_q [$];
	logic [`CHANNEL_WIDTH-1:0] chk_exp_q [$];
	logic exp_est_v = 1'b0;
	logic exp_chk_v = 1'b0;
	logic exp_est_first = 1'b0;
	int captured = 0;
	int cycles = 0;
	int flips = 0;
	int ties = 0;

	dsp_backend dut_i (.*);

	always #10 clk = ~clk;

	function automatic int rand_range(input int lo, input int hi);
		return lo + (($random(seed) & 32'h7fffffff) % (hi - lo + 1));
	endfunction

	function automatic int ref_ffe(input int n);
		int sum;
		int v;
		sum = 0;
		for (int j = 0; j < `FFE_TAPS; j++) begin
			if (n - j >= 0) begin
				sum += w_val[j] * code_hist[n-j];
			end
		end
		v = sum >>> shift_val;
		if (v > EST_HI) begin
			v = EST_HI;
		end else if (v < EST_LO) begin
			v = EST_LO;
		end
		return v;
	endfunction

	// picks the hypothesis closer to the code, ties keep the slicer bit.
	function automatic logic ref_mlsd(input int code, input logic left, input logic slicer,
		input logic right);
		int side;
		int err0;
		int err1;
		side = (right ? pre_val : -pre_val) + (left ? post_val : -post_val);
		err0 = code - (side - main_val);
		err1 = code - (side + main_val);
		err0 = (err0 < 0) ? -err0 : err0;
		err1 = (err1 < 0) ? -err1 : err1;
		if (err0 == err1) begin
			if (main_val != 0) begin
				ties++;
			end
			return slicer;
		end
		if ((err1 < err0) != slicer) begin
			flips++;
		end
		return err1 < err0;
	endfunction

	function automatic logic [`CHANNEL_WIDTH-1:0] ref_check(input int k);
		logic [`CHANNEL_WIDTH-1:0] res;
		int n;
		for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
			n = k * `CHANNEL_WIDTH + c;
			res[c] = ref_mlsd(code_hist[n], (n == 0) ? 1'b0 : bit_hist[n-1], bit_hist[n],
				bit_hist[n+1]);
		end
		return res;
	endfunction

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic load_config(input int w0, input int w1, input int w2, input int shift,
		input int thr, input int pre, input int main, input int post);
		w_val[0] = w0;
		w_val[1] = w1;
		w_val[2] = w2;
		shift_val = shift;
		thresh_val = thr;
		pre_val = pre;
		main_val = main;
		post_val = post;
		for (int j = 0; j < `FFE_TAPS; j++) begin
			weights_i[j] = w_val[j];
		end
		ffe_shift_i = shift_val;
		thresh_i = thresh_val;
		est_pre_i = pre_val;
		est_main_i = main_val;
		est_post_i = post_val;
	endtask

	task automatic fill_codes(input int lo, input int hi);
		for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
			frame_codes[c] = rand_range(lo, hi);
		end
	endtask

	// lets in-flight frames finish before the configuration moves.
	task automatic drain_pipeline();
		while (est_exp_q.size() != 0 || chk_exp_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	// queues the expectations, then drives the frame for one cycle.
	task automatic send_frame(input int gap);
		int base;
		int est;
		base = frame_count * `CHANNEL_WIDTH;
		for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
			code_hist[base+c] = frame_codes[c];
		end
		for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
			est = ref_ffe(base + c);
			est_exp_q.push_back(est);
			bit_hist[base+c] = (est >= thresh_val);
		end
		if (frame_count > 0) begin
			chk_exp_q.push_back(ref_check(frame_count - 1));
		end
		frame_count++;
		valid_i = 1'b1;
		for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
			codes_i[c] = frame_codes[c];
		end
		@(posedge clk);
		#2;
		valid_i = 1'b0;
		repeat (gap) begin
			@(posedge clk);
			#2;
		end
	endtask

	// valid timing follows valid_i by 1 and 2 cycles, frame 0 is never checked.
	always @(posedge clk) begin
		if (arst_n_i) begin
			if (est_valid_o && est_exp_q.size() < `CHANNEL_WIDTH) begin
				fail_run("estimate frame came out with no frame expected");
			end
			if (checked_valid_o && chk_exp_q.size() == 0) begin
				fail_run("checked bits came out with no frame expected");
			end
			check_value("est_valid_o", est_valid_o, exp_est_v);
			check_value("checked_valid_o", checked_valid_o, exp_chk_v);
			if (est_valid_o) begin
				for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
					check_value($sformatf("estimated_o[%0d]", c), estimated_o[c],
						est_exp_q.pop_front());
				end
			end
			if (checked_valid_o) begin
				check_value("checked_bits_o", checked_bits_o, chk_exp_q.pop_front());
			end
			exp_chk_v = exp_est_v && !exp_est_first;
			exp_est_first = valid_i && (captured == 0);
			exp_est_v = valid_i;
			if (valid_i) begin
				captured++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
		end
	end

	initial begin
		arst_n_i = 1'b0;
		valid_i = 1'b0;
		for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
			codes_i[c] = '0;
		end
		load_config(0, 0, 0, 0, 0, 0, 0, 0);
		repeat (2) @(posedge clk);
		#2;
		arst_n_i = 1'b1;
		// idle after reset, both valid outputs must stay low.
		repeat (5) @(posedge clk);
		#2;
		// full range codes and weights clip at both ends for small shifts.
		for (int s = 0; s < 8; s++) begin
			drain_pipeline();
			load_config(rand_range(-128, 127), rand_range(-128, 127), rand_range(-128, 127), s,
				rand_range(-200, 200), rand_range(-30, 30), rand_range(-60, 60), rand_range(-30, 30));
			repeat (20) begin
				fill_codes(-128, 127);
				send_frame(0);
			end
		end
		// estimate equals the code, zero channel so every hypothesis ties.
		for (int t = 0; t < 8; t++) begin
			drain_pipeline();
			load_config(1, 0, 0, 0, rand_range(-120, 120), 0, 0, 0);
			repeat (10) begin
				fill_codes(-128, 127);
				for (int c = 0; c < `CHANNEL_WIDTH; c++) begin
					if (rand_range(0, 3) != 0) begin
						frame_codes[c] = thresh_val + rand_range(-1, 1);
					end
				end
				send_frame(0);
			end
		end
		// strong main tap, noisy codes around a zero threshold.
		for (int e = 0; e < 5; e++) begin
			drain_pipeline();
			load_config(1, 0, 0, 0, 0, (e == 0) ? 0 : rand_range(-16, 16), rand_range(30, 60),
				(e == 0) ? 0 : rand_range(-16, 16));
			repeat (30) begin
				fill_codes(-64, 64);
				if (rand_range(0, 3) == 0) begin
					frame_codes[rand_range(0, `CHANNEL_WIDTH-1)] = 0;
				end
				send_frame(0);
			end
		end
		// bursts and idle gaps.
		for (int e = 0; e < 4; e++) begin
			drain_pipeline();
			load_config(rand_range(-40, 40), rand_range(-40, 40), rand_range(-40, 40),
				rand_range(0, 3), rand_range(-50, 50), rand_range(-16, 16), rand_range(20, 60),
				rand_range(-16, 16));
			repeat (30) begin
				fill_codes(-128, 127);
				send_frame((rand_range(0, 1) == 0) ? 0 : rand_range(1, 3));
			end
		end
		drain_pipeline();
		repeat (4) @(posedge clk);
		if (flips == 0 || ties == 0) begin
			fail_run("sequence check saw no corrected bit or no tie");
		end else begin
			$display("ALL CHECKS PASSED");
		end
		$finish;
	end

endmodule : tb_dsp_backend

//--- verilog.f
+incdir+hw
hw/dsp_pkg.sv
hw/ffe_slicer.sv
hw/decision_history.sv
hw/mlsd_checker.sv
hw/dsp_backend.sv
sim/tb_dsp_backend.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dsp_backend
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	@out=$$(./$(BUILD_DIR)/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(BUILD_DIR)
